// File: sim.f
+incdir+logic
logic/corep.sv
logic/ras.sv
logic/ras_wrapper.sv
logic/ras_hint_decode.sv
logic/ras_frontend.sv
verification/ras_frontend_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the RAS testbench with Verilator
# the run passes only if the testbench prints its pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module ras_frontend_tb -o ras_frontend_sim \
	|| { echo "verilator build failed"; exit 1; }

sim_out="$(./obj_dir/ras_frontend_sim)" \
	|| { echo "$sim_out"; echo "simulation exited with an error"; exit 1; }
echo "$sim_out"

echo "$sim_out" | grep -qx "TEST PASS" && exit 0 || exit 1

// File: verification/ras_frontend_tb.sv
/*
  table driven testbench for ras_frontend, expected values come from a stack model
  run while the table is built; outputs are checked two cycles after each row
*/

`timescale 1ns/100ps
`default_nettype none

`include "ras_cfg.svh"

module ras_frontend_tb import corep::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	localparam int MAX_ROWS = 64;
	// op-imm major opcode, never a stack action
	localparam logic [6:0] OP_IMM = 7'b0010011;

	// --------------------
	// dut signals

	logic CLK;
	logic nRST;
	logic fetch_valid;
	logic [31:0] fetch_instr;
	PC38_t fetch_pc;
	logic next_update_valid;
	RAS_idx_t next_update_ras_index;
	RAS_cnt_t next_update_ras_count;
	logic last_ret_fallback;
	PC38_t last_ret_pc38;
	RAS_idx_t last_ret_ras_index;
	RAS_cnt_t last_ret_ras_count;

	ras_frontend dut (
		.CLK(CLK),
		.nRST(nRST),
		.fetch_valid(fetch_valid),
		.fetch_instr(fetch_instr),
		.fetch_pc(fetch_pc),
		.next_update_valid(next_update_valid),
		.next_update_ras_index(next_update_ras_index),
		.next_update_ras_count(next_update_ras_count),
		.last_ret_fallback(last_ret_fallback),
		.last_ret_pc38(last_ret_pc38),
		.last_ret_ras_index(last_ret_ras_index),
		.last_ret_ras_count(last_ret_ras_count)
	);

	// --------------------
	// stimulus and expected table

	logic row_fetch_valid [0:MAX_ROWS-1];
	logic [31:0] row_instr [0:MAX_ROWS-1];
	PC38_t row_pc [0:MAX_ROWS-1];
	logic row_upd_valid [0:MAX_ROWS-1];
	RAS_idx_t row_upd_index [0:MAX_ROWS-1];
	RAS_cnt_t row_upd_count [0:MAX_ROWS-1];
	// held last_ret_* once the row has passed through
	logic exp_fallback [0:MAX_ROWS-1];
	PC38_t exp_pc [0:MAX_ROWS-1];
	RAS_idx_t exp_index [0:MAX_ROWS-1];
	RAS_cnt_t exp_count [0:MAX_ROWS-1];
	int num_rows;
	logic table_ready = 1'b0;

	// --------------------
	// stack model state

	PC38_t mdl_stack [0:`RAS_ENTRIES-1];
	RAS_idx_t mdl_index;
	RAS_cnt_t mdl_count;
	// what the output registers should hold
	logic mdl_fallback;
	PC38_t mdl_pc;
	RAS_idx_t mdl_rep_index;
	RAS_cnt_t mdl_rep_count;

	integer seed = 32'h91b1;
	int errors;
	int checks;
	int check_row;
	// rows in flight, two deep for the two cycle latency
	int lat_q [$];

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	function automatic logic [31:0] encode_instr(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [6:0] op);
		// i-type layout, imm and funct3 zero
		encode_instr = {12'h000, rs1, 3'b000, rd, op};
	endfunction

	task automatic draw_pc(output PC38_t pc);
		logic [63:0] r;
		r = {$random(seed), $random(seed)};
		// word aligned fetch address
		pc = PC38_t'(r) & ~PC38_t'(3);
	endtask

	task automatic push_entry(input PC38_t link);
		mdl_index = RAS_idx_t'((int'(mdl_index) + 1) % `RAS_ENTRIES);
		mdl_stack[mdl_index] = link;
		// full stack loses its oldest entry
		if (mdl_count < RAS_cnt_t'(`RAS_ENTRIES)) begin
			mdl_count = mdl_count + RAS_cnt_t'(1);
		end
	endtask

	task automatic model_step(input ras_act_t act, input PC38_t pc, input logic upd_valid,
		input RAS_idx_t upd_index, input RAS_cnt_t upd_count);
		PC38_t link;
		link = pc + PC38_t'(`LINK_INC);
		if (upd_valid) begin
			// restore only, a pop or push alongside it is lost
			mdl_index = upd_index;
			mdl_count = upd_count;
		end
		else begin
			// a return reports the state from before its own action
			if (act == ACT_POP || act == ACT_POP_PUSH) begin
				mdl_fallback = (mdl_count == '0);
				mdl_pc = (mdl_count == '0) ? '0 : mdl_stack[mdl_index];
				mdl_rep_index = mdl_index;
				mdl_rep_count = mdl_count;
			end
			case (act)
				ACT_PUSH: push_entry(link);
				ACT_POP: begin
					if (mdl_count != '0) begin
						mdl_index = RAS_idx_t'((int'(mdl_index) + `RAS_ENTRIES - 1) % `RAS_ENTRIES);
						mdl_count = mdl_count - RAS_cnt_t'(1);
					end
				end
				ACT_POP_PUSH: begin
					// empty stack turns into a plain push
					if (mdl_count == '0) begin
						push_entry(link);
					end
					else begin
						mdl_stack[mdl_index] = link;
					end
				end
				default: begin
				end
			endcase
		end
	endtask

	// act is the hint the row is written to exercise
	task automatic add_row(input logic valid, input logic [4:0] rd, input logic [4:0] rs1,
		input logic [6:0] op, input ras_act_t act, input logic upd_valid,
		input RAS_idx_t upd_index, input RAS_cnt_t upd_count);
		PC38_t pc;
		ras_act_t eff_act;
		draw_pc(pc);
		eff_act = ACT_NONE;
		if (valid) begin
			eff_act = act;
		end
		row_fetch_valid[num_rows] = valid;
		row_instr[num_rows] = encode_instr(rd, rs1, op);
		row_pc[num_rows] = pc;
		row_upd_valid[num_rows] = upd_valid;
		row_upd_index[num_rows] = upd_index;
		row_upd_count[num_rows] = upd_count;
		model_step(eff_act, pc, upd_valid, upd_index, upd_count);
		exp_fallback[num_rows] = mdl_fallback;
		exp_pc[num_rows] = mdl_pc;
		exp_index[num_rows] = mdl_rep_index;
		exp_count[num_rows] = mdl_rep_count;
		num_rows++;
	endtask

	task automatic fetch_row(input logic [4:0] rd, input logic [4:0] rs1, input logic [6:0] op,
		input ras_act_t act);
		add_row(1'b1, rd, rs1, op, act, 1'b0, '0, '0);
	endtask

	task automatic build_table();
		RAS_idx_t saved_index;
		RAS_cnt_t saved_count;
		num_rows = 0;
		for (int i = 0; i < `RAS_ENTRIES; i++) begin
			mdl_stack[i] = '0;
		end
		mdl_index = '0;
		mdl_count = '0;
		mdl_fallback = 1'b0;
		mdl_pc = '0;
		mdl_rep_index = '0;
		mdl_rep_count = '0;
		// out of reset, the first returns find nothing
		fetch_row(5'd0, 5'd1, OP_JALR, ACT_POP);
		fetch_row(5'd0, 5'd5, OP_JALR, ACT_POP);
		// nested calls, then returns in reverse order
		repeat (3) fetch_row(5'd1, 5'd0, OP_JAL, ACT_PUSH);
		repeat (3) fetch_row(5'd0, 5'd1, OP_JALR, ACT_POP);
		// empty pops, count stays zero
		repeat (2) fetch_row(5'd0, 5'd1, OP_JALR, ACT_POP);
		// overflow, two oldest of ten calls lost, ninth pop falls back
		repeat (10) fetch_row(5'd5, 5'd0, OP_JAL, ACT_PUSH);
		repeat (9) fetch_row(5'd0, 5'd5, OP_JALR, ACT_POP);
		// --------------------
		// hint table cases
		fetch_row(5'd1, 5'd0, OP_JAL, ACT_PUSH);
		fetch_row(5'd5, 5'd1, OP_JALR, ACT_POP_PUSH);
		fetch_row(5'd1, 5'd1, OP_JALR, ACT_PUSH);
		fetch_row(5'd0, 5'd0, OP_JAL, ACT_NONE);
		fetch_row(5'd1, 5'd5, OP_IMM, ACT_NONE);
		// call word without fetch_valid
		add_row(1'b0, 5'd1, 5'd0, OP_JAL, ACT_PUSH, 1'b0, '0, '0);
		repeat (3) fetch_row(5'd0, 5'd1, OP_JALR, ACT_POP);
		// --------------------
		// checkpoint restore
		repeat (3) fetch_row(5'd1, 5'd0, OP_JAL, ACT_PUSH);
		fetch_row(5'd0, 5'd1, OP_JALR, ACT_POP);
		saved_index = mdl_rep_index;
		saved_count = mdl_rep_count;
		fetch_row(5'd0, 5'd1, OP_JALR, ACT_POP);
		// pop alongside the restore is dropped
		add_row(1'b1, 5'd0, 5'd1, OP_JALR, ACT_POP, 1'b1, saved_index, saved_count);
		repeat (4) fetch_row(5'd0, 5'd1, OP_JALR, ACT_POP);
		table_ready = 1'b1;
	endtask

	task automatic check_value(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t: row %0d %s is %0h, expected %0h",
				$time, check_row, what, got, exp);
		end
	endtask

	task automatic compare_outputs(input int j);
		check_row = j;
		check_value("last_ret_fallback", 64'(last_ret_fallback), 64'(exp_fallback[j]));
		check_value("last_ret_pc38", 64'(last_ret_pc38), 64'(exp_pc[j]));
		check_value("last_ret_ras_index", 64'(last_ret_ras_index), 64'(exp_index[j]));
		check_value("last_ret_ras_count", 64'(last_ret_ras_count), 64'(exp_count[j]));
	endtask

	task automatic retire_row(input int depth);
		int j;
		if (lat_q.size() >= depth) begin
			j = lat_q.pop_front();
			compare_outputs(j);
		end
	endtask

	task automatic apply_row(input int i);
		fetch_valid = row_fetch_valid[i];
		fetch_instr = row_instr[i];
		fetch_pc = row_pc[i];
		next_update_valid = row_upd_valid[i];
		next_update_ras_index = row_upd_index[i];
		next_update_ras_count = row_upd_count[i];
	endtask

	task automatic drive_idle();
		fetch_valid = 1'b0;
		fetch_instr = '0;
		fetch_pc = '0;
		next_update_valid = 1'b0;
		next_update_ras_index = '0;
		next_update_ras_count = '0;
	endtask

	// --------------------
	// main sequence

	initial begin
		nRST = 1'b0;
		drive_idle();
		errors = 0;
		checks = 0;
		check_row = -1;
		build_table();
		repeat (RESET_CYCLES) @(posedge CLK);
		#1;
		nRST = 1'b1;
		// outputs cleared by reset
		check_value("reset last_ret_fallback", 64'(last_ret_fallback), 64'(0));
		check_value("reset last_ret_pc38", 64'(last_ret_pc38), 64'(0));
		check_value("reset last_ret_ras_index", 64'(last_ret_ras_index), 64'(0));
		check_value("reset last_ret_ras_count", 64'(last_ret_ras_count), 64'(0));
		for (int i = 0; i < num_rows; i++) begin
			@(posedge CLK);
			#1;
			retire_row(2);
			apply_row(i);
			lat_q.push_back(i);
		end
		// drain the last two rows
		repeat (2) begin
			@(posedge CLK);
			#1;
			retire_row(1);
			drive_idle();
		end
		$display("rows %0d, checks %0d, errors %0d", num_rows, checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end
		else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	// watchdog, sized from the table once it exists
	initial begin
		wait (table_ready);
		#((num_rows + RESET_CYCLES + 20) * CLK_PERIOD);
		$display("the run timed out before all table rows were checked");
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/ras_frontend.sv
/*
  fetch side RAS slice, decoder feeding the registered stack
  fetch to last_ret_* is two cycles, update feeds the stack directly
*/

`timescale 1ns/100ps
`default_nettype none

module ras_frontend import corep::*; (
	input logic CLK,
	input logic nRST,

	// fetched instruction
	input logic fetch_valid,
	input logic [31:0] fetch_instr,
	input PC38_t fetch_pc,

	// checkpoint restore from the backend
	input logic next_update_valid,
	input RAS_idx_t next_update_ras_index,
	input RAS_cnt_t next_update_ras_count,

	// prediction for the most recent return
	output logic last_ret_fallback,
	output PC38_t last_ret_pc38,
	output RAS_idx_t last_ret_ras_index,
	output RAS_cnt_t last_ret_ras_count
);

	// --------------------
	// decoder to stack

	logic next_link_valid;
	PC38_t next_link_pc38;
	logic next_ret_valid;

	ras_hint_decode hint_decode (
		.fetch_valid(fetch_valid),
		.fetch_instr(fetch_instr),
		.fetch_pc(fetch_pc),
		.next_link_valid(next_link_valid),
		.next_link_pc38(next_link_pc38),
		.next_ret_valid(next_ret_valid)
	);

	// registered stack
	ras_wrapper stack (
		.CLK(CLK),
		.nRST(nRST),
		.next_link_valid(next_link_valid),
		.next_link_pc38(next_link_pc38),
		.next_ret_valid(next_ret_valid),
		.last_ret_fallback(last_ret_fallback),
		.last_ret_pc38(last_ret_pc38),
		.last_ret_ras_index(last_ret_ras_index),
		.last_ret_ras_count(last_ret_ras_count),
		.next_update_valid(next_update_valid),
		.next_update_ras_index(next_update_ras_index),
		.next_update_ras_count(next_update_ras_count)
	);

endmodule

`default_nettype wire

// File: logic/ras_hint_decode.sv
/*
  RISC-V return address hint decode for JAL and JALR, purely combinational
  funct3 of JALR is not checked, an illegal word is assumed to be caught later
  link address assumes 4-byte calls
*/

`timescale 1ns/100ps
`default_nettype none

`include "ras_cfg.svh"

module ras_hint_decode import corep::*; (
	input logic fetch_valid,
	input logic [31:0] fetch_instr,
	input PC38_t fetch_pc,

	output logic next_link_valid,
	output PC38_t next_link_pc38,
	output logic next_ret_valid
);

	// --------------------
	// field extract

	logic [6:0] opcode;
	logic [4:0] rd;
	logic [4:0] rs1;
	logic rd_link;
	logic rs1_link;
	ras_act_t act;

	assign opcode = fetch_instr[6:0];
	assign rd = fetch_instr[11:7];
	assign rs1 = fetch_instr[19:15];

	// x1 and x5 are the link registers
	assign rd_link = (rd == REG_RA) || (rd == REG_T0);
	assign rs1_link = (rs1 == REG_RA) || (rs1 == REG_T0);

	// --------------------
	// hint table

	always_comb begin
		act = ACT_NONE;
		if (fetch_valid) begin
			case (opcode)
				OP_JAL: begin
					// call only when linking
					if (rd_link) act = ACT_PUSH;
				end
				OP_JALR: begin
					case ({rd_link, rs1_link})
						2'b10: act = ACT_PUSH;
						2'b01: act = ACT_POP;
						// coroutine swap unless same register
						2'b11: act = (rd == rs1) ? ACT_PUSH : ACT_POP_PUSH;
						default: act = ACT_NONE;
					endcase
				end
				default: act = ACT_NONE;
			endcase
		end
	end

	// --------------------
	// strobes and link address

	assign next_link_valid = (act == ACT_PUSH) || (act == ACT_POP_PUSH);
	assign next_ret_valid = (act == ACT_POP) || (act == ACT_POP_PUSH);
	assign next_link_pc38 = fetch_pc + PC38_t'(`LINK_INC);

endmodule

`default_nettype wire

// File: logic/ras_wrapper.sv
/*
  one register stage in front of and behind the stack core
  two cycles from next_* strobes to last_ret_*
  last_ret_* load only on a return that is not blocked by an update
*/

`timescale 1ns/100ps
`default_nettype none

module ras_wrapper import corep::*; (
	input logic CLK,
	input logic nRST,

	// link control from pc gen
	input logic next_link_valid,
	input PC38_t next_link_pc38,

	// return control from pc gen
	input logic next_ret_valid,
	output logic last_ret_fallback,
	output PC38_t last_ret_pc38,
	output RAS_idx_t last_ret_ras_index,
	output RAS_cnt_t last_ret_ras_count,

	// update control
	input logic next_update_valid,
	input RAS_idx_t next_update_ras_index,
	input RAS_cnt_t next_update_ras_count
);

	// --------------------
	// core side signals

	logic link_valid;
	PC38_t link_pc38;
	logic ret_valid;
	logic ret_fallback;
	PC38_t ret_pc38;
	RAS_idx_t ret_ras_index;
	RAS_cnt_t ret_ras_count;
	logic update_valid;
	RAS_idx_t update_ras_index;
	RAS_cnt_t update_ras_count;

	// return actually seen by the core this cycle
	logic ret_taken;

	ras wrapped_ras (
		.CLK(CLK),
		.nRST(nRST),
		.link_valid(link_valid),
		.link_pc38(link_pc38),
		.ret_valid(ret_valid),
		.ret_fallback(ret_fallback),
		.ret_pc38(ret_pc38),
		.ret_ras_index(ret_ras_index),
		.ret_ras_count(ret_ras_count),
		.update_valid(update_valid),
		.update_ras_index(update_ras_index),
		.update_ras_count(update_ras_count)
	);

	// restore drops a pop in the same cycle
	assign ret_taken = ret_valid && !update_valid;

	// --------------------
	// input registers

	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			link_valid <= 1'b0;
			link_pc38 <= '0;
			ret_valid <= 1'b0;
			update_valid <= 1'b0;
			update_ras_index <= '0;
			update_ras_count <= '0;
		end
		else begin
			link_valid <= next_link_valid;
			link_pc38 <= next_link_pc38;
			ret_valid <= next_ret_valid;
			update_valid <= next_update_valid;
			update_ras_index <= next_update_ras_index;
			update_ras_count <= next_update_ras_count;
		end
	end

	// --------------------
	// output registers, hold between returns

	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			last_ret_fallback <= 1'b0;
			last_ret_pc38 <= '0;
			last_ret_ras_index <= '0;
			last_ret_ras_count <= '0;
		end
		else if (ret_taken) begin
			last_ret_fallback <= ret_fallback;
			last_ret_pc38 <= ret_pc38;
			last_ret_ras_index <= ret_ras_index;
			last_ret_ras_count <= ret_ras_count;
		end
	end

endmodule

`default_nettype wire

// File: logic/ras.sv
/*
  circular return address stack, combinational read, state changes at CLK
  full stack silently overwrites the oldest entry on push
  reported index and count are always the state before the action
*/

`timescale 1ns/100ps
`default_nettype none

`include "ras_cfg.svh"

module ras import corep::*; (
	input logic CLK,
	input logic nRST,

	// link request, push of a return address
	input logic link_valid,
	input PC38_t link_pc38,

	// return request, pop of the predicted target
	input logic ret_valid,
	output logic ret_fallback,
	output PC38_t ret_pc38,
	output RAS_idx_t ret_ras_index,
	output RAS_cnt_t ret_ras_count,

	// checkpoint restore after a mispredict
	input logic update_valid,
	input RAS_idx_t update_ras_index,
	input RAS_cnt_t update_ras_count
);

	// --------------------
	// stack state

	PC38_t entries [0:`RAS_ENTRIES-1];
	// slot holding the most recent return address
	RAS_idx_t top_index;
	RAS_cnt_t top_count;

	ras_act_t act;
	logic empty;
	logic full;
	RAS_idx_t index_inc;
	RAS_idx_t index_dec;

	// --------------------
	// action and pointer math

	// two strobes map straight onto the action encoding
	always_comb begin
		case ({link_valid, ret_valid})
			2'b10: act = ACT_PUSH;
			2'b01: act = ACT_POP;
			2'b11: act = ACT_POP_PUSH;
			default: act = ACT_NONE;
		endcase
	end

	assign empty = (top_count == '0);
	assign full = (top_count == RAS_cnt_t'(`RAS_ENTRIES));

	// wrap relies on power of two depth
	assign index_inc = top_index + RAS_idx_t'(1);
	assign index_dec = top_index - RAS_idx_t'(1);

	// --------------------
	// return read port

	// empty stack has no prediction, fetch falls back
	assign ret_fallback = empty;
	assign ret_pc38 = empty ? '0 : entries[top_index];

	// checkpoint for a later restore
	assign ret_ras_index = top_index;
	assign ret_ras_count = top_count;

	// --------------------
	// state update

	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			for (int i = 0; i < `RAS_ENTRIES; i++) begin
				entries[i] <= '0;
			end
			top_index <= '0;
			top_count <= '0;
		end
		else if (update_valid) begin
			// restore wins, any push or pop this cycle is dropped
			top_index <= update_ras_index;
			top_count <= update_ras_count;
		end
		else begin
			case (act)
				ACT_PUSH: begin
					top_index <= index_inc;
					entries[index_inc] <= link_pc38;
					// saturate, oldest slot is reused once full
					if (!full) begin
						top_count <= top_count + RAS_cnt_t'(1);
					end
				end
				ACT_POP: begin
					// empty pop reports fallback only
					if (!empty) begin
						top_index <= index_dec;
						top_count <= top_count - RAS_cnt_t'(1);
					end
				end
				ACT_POP_PUSH: begin
					if (empty) begin
						// nothing to replace, plain push
						top_index <= index_inc;
						entries[index_inc] <= link_pc38;
						top_count <= RAS_cnt_t'(1);
					end
					else begin
						// top read above, same slot takes the new link
						entries[top_index] <= link_pc38;
					end
				end
				default: begin
					// no action, hold state
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/corep.sv
/*
  shared types for the RAS fetch slice
  widths come from ras_cfg.svh, opcode values are the RV32/RV64 major opcodes
*/

`default_nettype none

`include "ras_cfg.svh"

package corep;

	// --------------------
	// pc and stack state

	// byte address pc
	typedef logic [`PC_WIDTH-1:0] PC38_t;

	// slot pointer into the stack array
	typedef logic [`RAS_IDX_BITS-1:0] RAS_idx_t;

	// valid entry count, one extra bit so full is representable
	typedef logic [`RAS_IDX_BITS:0] RAS_cnt_t;

	// stack action formed from link and return strobes
	typedef enum logic [1:0] {
		ACT_NONE     = 2'b00,
		ACT_PUSH     = 2'b10,
		ACT_POP      = 2'b01,
		ACT_POP_PUSH = 2'b11
	} ras_act_t;

	// --------------------
	// instruction fields

	// major opcodes that can touch the stack
	typedef enum logic [6:0] {
		OP_JAL  = 7'b1101111,
		OP_JALR = 7'b1100111
	} rv_opcode_t;

	// registers the hint rules treat as link registers
	typedef enum logic [4:0] {
		REG_RA = 5'd1,
		REG_T0 = 5'd5
	} rv_link_reg_t;

endpackage

`default_nettype wire

// File: logic/ras_cfg.svh
/*
  return address stack geometry and PC sizing
  RAS_ENTRIES must equal 2**RAS_IDX_BITS since the top index wraps naturally
  PC is a byte address, LINK_INC assumes 32-bit call instructions only
*/

`ifndef RAS_CFG_SVH
`define RAS_CFG_SVH

// --------------------
// stack geometry

// number of predicted return addresses held
`define RAS_ENTRIES 8
// slot index width, log2 of RAS_ENTRIES
`define RAS_IDX_BITS 3

// --------------------
// pc sizing

`define PC_WIDTH 38
// call pc to return address, no compressed calls
`define LINK_INC 4

`endif
